// File: rtl/core_pkg.sv
`default_nettype none

package core_pkg;

    localparam int word_w     = 32;
    localparam int reg_addr_w = 5;
    localparam int num_regs   = 32;

    // data word, instruction word or byte address
    typedef logic [word_w-1:0] word_t;

    typedef logic [reg_addr_w-1:0] reg_addr_t;

    // alu operations of the supported subset
    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_slt
    } alu_op_t;

endpackage

`default_nettype wire

// File: rtl/isa_pkg.sv
`default_nettype none

package isa_pkg;

    // major opcodes in the supported subset
    typedef enum logic [6:0] {
        op_reg = 7'b0110011,
        op_imm = 7'b0010011
    } opcode_t;

    // funct3 values
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_srl     = 3'b101;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    // funct7 values, alt selects sub
    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_alt  = 7'b0100000;

    // field positions within the instruction word
    localparam int opcode_lsb = 0;
    localparam int opcode_msb = 6;
    localparam int rd_lsb     = 7;
    localparam int rd_msb     = 11;
    localparam int funct3_lsb = 12;
    localparam int funct3_msb = 14;
    localparam int rs1_lsb    = 15;
    localparam int rs1_msb    = 19;
    localparam int rs2_lsb    = 20;
    localparam int rs2_msb    = 24;
    localparam int funct7_lsb = 25;
    localparam int funct7_msb = 31;
    localparam int imm_i_lsb  = 20;
    localparam int imm_i_msb  = 31;

endpackage

`default_nettype wire

// File: rtl/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit #(
    parameter int imem_depth = 32
) (
    input  wire logic           clk,
    input  wire logic           rst,
    input  wire logic           imem_we,
    input  wire core_pkg::word_t imem_waddr,
    input  wire core_pkg::word_t imem_wdata,
    output core_pkg::word_t     pc,
    output core_pkg::word_t     instruction
);

    import core_pkg::*;

    localparam int addr_w = (imem_depth > 1) ? $clog2(imem_depth) : 1;

    // byte address of the last word, pc wraps after it
    localparam word_t last_pc = word_t'((imem_depth - 1) * 4);

    word_t mem [imem_depth];

    logic [addr_w-1:0] rd_idx;
    logic [addr_w-1:0] wr_idx;

    assign rd_idx = pc[addr_w+1:2];
    assign wr_idx = imem_waddr[addr_w-1:0];

    // asynchronous read at the word index of pc
    assign instruction = mem[rd_idx];

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else if (pc == last_pc) begin
            pc <= '0;
        end else begin
            pc <= pc + word_t'(4);
        end
    end

    // load port, also usable while rst is held
    always_ff @(posedge clk) begin
        if (imem_we && (imem_waddr < word_t'(imem_depth))) begin
            mem[wr_idx] <= imem_wdata;
        end
    end

endmodule

`default_nettype wire

// File: rtl/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire core_pkg::reg_addr_t rs1_addr,
    input  wire core_pkg::reg_addr_t rs2_addr,
    output core_pkg::word_t         rs1_data,
    output core_pkg::word_t         rs2_data,
    input  wire logic               wr_en,
    input  wire core_pkg::reg_addr_t wr_addr,
    input  wire core_pkg::word_t     wr_data,
    input  wire core_pkg::reg_addr_t dbg_addr,
    output core_pkg::word_t         dbg_data
);

    import core_pkg::*;

    word_t regs [num_regs];

    // all three read ports are combinational
    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];
    assign dbg_data = regs[dbg_addr];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_addr != '0)) begin
            // x0 never takes a write
            regs[wr_addr] <= wr_data;
        end
    end

endmodule

`default_nettype wire

// File: rtl/execute_unit.sv
`timescale 1ns/1ps
`default_nettype none

module execute_unit (
    input  wire logic                rst,
    input  wire core_pkg::word_t     instruction,
    output core_pkg::reg_addr_t      rs1_addr,
    output core_pkg::reg_addr_t      rs2_addr,
    input  wire core_pkg::word_t     rs1_data,
    input  wire core_pkg::word_t     rs2_data,
    output logic                     wr_en,
    output core_pkg::reg_addr_t      wr_addr,
    output core_pkg::word_t          wr_data
);

    import core_pkg::*;
    import isa_pkg::*;

    opcode_t    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm_i;
    alu_op_t    alu_op;
    logic       use_imm;
    logic       supported;
    word_t      operand_a;
    word_t      operand_b;
    logic [4:0] shamt;
    word_t      alu_result;

    // instruction fields
    assign opcode   = opcode_t'(instruction[opcode_msb:opcode_lsb]);
    assign funct3   = instruction[funct3_msb:funct3_lsb];
    assign funct7   = instruction[funct7_msb:funct7_lsb];
    assign rs1_addr = instruction[rs1_msb:rs1_lsb];
    assign rs2_addr = instruction[rs2_msb:rs2_lsb];
    assign wr_addr  = instruction[rd_msb:rd_lsb];

    // sign-extended 12-bit immediate
    assign imm_i = {{20{instruction[imm_i_msb]}}, instruction[imm_i_msb:imm_i_lsb]};

    always_comb begin
        alu_op    = alu_add;
        use_imm   = 1'b0;
        supported = 1'b0;
        case (opcode)
            op_reg: begin
                supported = (funct7 == f7_base);
                case (funct3)
                    f3_add_sub: begin
                        if (funct7 == f7_alt) begin
                            alu_op    = alu_sub;
                            supported = 1'b1;
                        end else begin
                            alu_op = alu_add;
                        end
                    end
                    f3_sll: alu_op = alu_sll;
                    f3_slt: alu_op = alu_slt;
                    f3_xor: alu_op = alu_xor;
                    // sra (f7_alt) stays unsupported
                    f3_srl: alu_op = alu_srl;
                    f3_or:  alu_op = alu_or;
                    f3_and: alu_op = alu_and;
                    default: supported = 1'b0;
                endcase
            end
            op_imm: begin
                // only addi from the I-type group
                use_imm   = 1'b1;
                supported = (funct3 == f3_add_sub);
            end
            default: begin
                supported = 1'b0;
            end
        endcase
    end

    assign operand_a = rs1_data;
    assign operand_b = use_imm ? imm_i : rs2_data;
    assign shamt     = operand_b[4:0];

    always_comb begin
        case (alu_op)
            alu_add: alu_result = operand_a + operand_b;
            alu_sub: alu_result = operand_a - operand_b;
            alu_and: alu_result = operand_a & operand_b;
            alu_or:  alu_result = operand_a | operand_b;
            alu_xor: alu_result = operand_a ^ operand_b;
            alu_sll: alu_result = operand_a << shamt;
            alu_srl: alu_result = operand_a >> shamt;
            alu_slt: alu_result = {31'b0, $signed(operand_a) < $signed(operand_b)};
            default: alu_result = '0;
        endcase
    end

    // unsupported words retire as no-ops
    assign wr_en   = supported && !rst;
    assign wr_data = alu_result;

endmodule

`default_nettype wire

// File: rtl/rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core #(
    parameter int imem_depth = 32
) (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                imem_we,
    input  wire core_pkg::word_t     imem_waddr,
    input  wire core_pkg::word_t     imem_wdata,
    output core_pkg::word_t          pc,
    output logic                     wb_en,
    output core_pkg::reg_addr_t      wb_rd,
    output core_pkg::word_t          wb_data,
    input  wire core_pkg::reg_addr_t dbg_addr,
    output core_pkg::word_t          dbg_data
);

    import core_pkg::*;

    word_t     instruction;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    word_t     rs1_data;
    word_t     rs2_data;

    fetch_unit #(
        .imem_depth(imem_depth)
    ) fetch0 (
        .clk(clk),
        .rst(rst),
        .imem_we(imem_we),
        .imem_waddr(imem_waddr),
        .imem_wdata(imem_wdata),
        .pc(pc),
        .instruction(instruction)
    );

    // write strobe doubles as the write-back outputs
    register_file regfile0 (
        .clk(clk),
        .rst(rst),
        .rs1_addr(rs1_addr),
        .rs2_addr(rs2_addr),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data),
        .wr_en(wb_en),
        .wr_addr(wb_rd),
        .wr_data(wb_data),
        .dbg_addr(dbg_addr),
        .dbg_data(dbg_data)
    );

    execute_unit exec0 (
        .rst(rst),
        .instruction(instruction),
        .rs1_addr(rs1_addr),
        .rs2_addr(rs2_addr),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data),
        .wr_en(wb_en),
        .wr_addr(wb_rd),
        .wr_data(wb_data)
    );

endmodule

`default_nettype wire

// File: include/tb_encode.svh
`ifndef TB_ENCODE_SVH
`define TB_ENCODE_SVH

// R-type word for one of the supported register ops
function automatic word_t encode_r(
    alu_op_t   op,
    reg_addr_t rd,
    reg_addr_t rs1,
    reg_addr_t rs2
);
    word_t      w;
    logic [2:0] f3;
    logic [6:0] f7;
    f7 = f7_base;
    case (op)
        alu_add: f3 = f3_add_sub;
        alu_sub: begin
            f3 = f3_add_sub;
            f7 = f7_alt;
        end
        alu_and: f3 = f3_and;
        alu_or:  f3 = f3_or;
        alu_xor: f3 = f3_xor;
        alu_sll: f3 = f3_sll;
        alu_srl: f3 = f3_srl;
        alu_slt: f3 = f3_slt;
        default: f3 = f3_add_sub;
    endcase
    w = '0;
    w[opcode_msb:opcode_lsb] = op_reg;
    w[rd_msb:rd_lsb]         = rd;
    w[funct3_msb:funct3_lsb] = f3;
    w[rs1_msb:rs1_lsb]       = rs1;
    w[rs2_msb:rs2_lsb]       = rs2;
    w[funct7_msb:funct7_lsb] = f7;
    return w;
endfunction

// addi with a raw 12-bit immediate
function automatic word_t encode_addi(reg_addr_t rd, reg_addr_t rs1, logic [11:0] imm);
    word_t w;
    w = '0;
    w[opcode_msb:opcode_lsb] = op_imm;
    w[rd_msb:rd_lsb]         = rd;
    w[funct3_msb:funct3_lsb] = f3_add_sub;
    w[rs1_msb:rs1_lsb]       = rs1;
    w[imm_i_msb:imm_i_lsb]   = imm;
    return w;
endfunction

`endif

// File: sim/tb_rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core;

    import core_pkg::*;
    import isa_pkg::*;

    `include "tb_encode.svh"

    localparam int imem_depth = 32;
    // seven loads of 32 cycles plus the programs come to about 320 cycles
    localparam int max_cycles = 2000;

    localparam logic [1:0] kind_r    = 2'd0;
    localparam logic [1:0] kind_addi = 2'd1;
    localparam logic [1:0] kind_nop  = 2'd2;

    typedef struct packed {
        logic [1:0] kind;
        alu_op_t    op;
        reg_addr_t  rd;
        reg_addr_t  rs1;
        reg_addr_t  rs2;
        word_t      imm;
        word_t      word;
    } prog_entry_t;

    logic      clk;
    logic      rst;
    logic      imem_we;
    word_t     imem_waddr;
    word_t     imem_wdata;
    word_t     pc;
    logic      wb_en;
    reg_addr_t wb_rd;
    word_t     wb_data;
    reg_addr_t dbg_addr;
    word_t     dbg_data;

    prog_entry_t prog [$];
    word_t       exp_regs [num_regs];
    word_t       exp_pc;
    word_t       rng_state = 32'h32e0;
    int          cycle_count = 0;

    rv_core #(
        .imem_depth(imem_depth)
    ) dut0 (
        .clk(clk),
        .rst(rst),
        .imem_we(imem_we),
        .imem_waddr(imem_waddr),
        .imem_wdata(imem_wdata),
        .pc(pc),
        .wb_en(wb_en),
        .wb_rd(wb_rd),
        .wb_data(wb_data),
        .dbg_addr(dbg_addr),
        .dbg_data(dbg_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic stop_with_failure();
        $display("Some tests failed");
        $fatal(1, "run stopped at the first failure");
    endtask

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > max_cycles) begin
            $display("Timed out: the tests did not finish within %0d cycles", max_cycles);
            stop_with_failure();
        end
    end

    task automatic check_word(string name, word_t actual, word_t expected);
        if (actual !== expected) begin
            $display("ERROR: %s = 0x%h, expected 0x%h", name, actual, expected);
            stop_with_failure();
        end
    endtask

    task automatic check_reg(string name, reg_addr_t actual, reg_addr_t expected);
        if (actual !== expected) begin
            $display("ERROR: %s = 0x%h, expected 0x%h", name, actual, expected);
            stop_with_failure();
        end
    endtask

    task automatic check_flag(string name, logic actual, logic expected);
        if (actual !== expected) begin
            $display("ERROR: %s = 0x%h, expected 0x%h", name, actual, expected);
            stop_with_failure();
        end
    endtask

    // inputs change 1 ns after the rising edge
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    function automatic word_t next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // any register but x0
    function automatic reg_addr_t rand_reg();
        return reg_addr_t'(1 + (next_random() % 31));
    endfunction

    function automatic logic [11:0] rand_imm();
        word_t r;
        r = next_random();
        return r[11:0];
    endfunction

    function automatic word_t sign_extend(logic [11:0] imm);
        return word_t'($signed(imm));
    endfunction

    // reference ALU
    function automatic word_t model_alu(alu_op_t op, word_t a, word_t b);
        case (op)
            alu_add: return a + b;
            alu_sub: return a - b;
            alu_and: return a & b;
            alu_or:  return a | b;
            alu_xor: return a ^ b;
            alu_sll: return a << b[4:0];
            alu_srl: return a >> b[4:0];
            default: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        endcase
    endfunction

    function automatic word_t expected_result(prog_entry_t e);
        word_t b;
        if (e.kind == kind_addi) begin
            b = e.imm;
        end else begin
            b = exp_regs[e.rs2];
        end
        return model_alu(e.op, exp_regs[e.rs1], b);
    endfunction

    task automatic push_r(alu_op_t op, reg_addr_t rd, reg_addr_t rs1, reg_addr_t rs2);
        prog_entry_t e;
        e = '0;
        e.kind = kind_r;
        e.op = op;
        e.rd = rd;
        e.rs1 = rs1;
        e.rs2 = rs2;
        e.word = encode_r(op, rd, rs1, rs2);
        prog.push_back(e);
    endtask

    task automatic push_addi(reg_addr_t rd, reg_addr_t rs1, logic [11:0] imm);
        prog_entry_t e;
        e = '0;
        e.kind = kind_addi;
        e.op = alu_add;
        e.rd = rd;
        e.rs1 = rs1;
        e.imm = sign_extend(imm);
        e.word = encode_addi(rd, rs1, imm);
        prog.push_back(e);
    endtask

    task automatic push_raw(word_t w);
        prog_entry_t e;
        e = '0;
        e.kind = kind_nop;
        e.word = w;
        prog.push_back(e);
    endtask

    // rewrites the whole memory under reset with zero in unused words
    task automatic load_program();
        rst = 1'b1;
        for (int i = 0; i < imem_depth; i++) begin
            imem_we = 1'b1;
            imem_waddr = word_t'(i);
            imem_wdata = (i < prog.size()) ? prog[i].word : '0;
            #1;
            check_flag("wb_en", wb_en, 1'b0);
            step();
        end
        imem_we = 1'b0;
        for (int r = 0; r < num_regs; r++) begin
            exp_regs[r] = '0;
        end
        exp_pc = '0;
    endtask

    task automatic run_program();
        reg_addr_t   last_rd;
        word_t       result;
        prog_entry_t e;
        last_rd = '0;
        result = '0;
        rst = 1'b0;
        for (int i = 0; i < prog.size(); i++) begin
            e = prog[i];
            // debug port shows the previous write
            dbg_addr = last_rd;
            #1;
            check_word("dbg_data", dbg_data, exp_regs[last_rd]);
            check_word("pc", pc, exp_pc);
            if (e.kind == kind_nop) begin
                check_flag("wb_en", wb_en, 1'b0);
                last_rd = '0;
            end else begin
                result = expected_result(e);
                check_flag("wb_en", wb_en, 1'b1);
                check_reg("wb_rd", wb_rd, e.rd);
                check_word("wb_data", wb_data, result);
                last_rd = e.rd;
            end
            step();
            if (e.kind != kind_nop && e.rd != '0) begin
                exp_regs[e.rd] = result;
            end
            exp_pc = (exp_pc == word_t'((imem_depth - 1) * 4)) ? '0 : exp_pc + 32'd4;
        end
        dbg_addr = last_rd;
        #1;
        check_word("dbg_data", dbg_data, exp_regs[last_rd]);
        check_word("pc", pc, exp_pc);
    endtask

    // all 32 reads fit inside one clock period
    task automatic sweep_regs();
        for (int r = 0; r < num_regs; r++) begin
            dbg_addr = reg_addr_t'(r);
            #0.15;
            check_word($sformatf("dbg_data[x%0d]", r), dbg_data, exp_regs[r]);
        end
    endtask

    task automatic test_reset();
        prog.delete();
        push_addi(5'd1, 5'd0, 12'h123);
        push_addi(5'd2, 5'd1, 12'hfff);
        load_program();
        run_program();
        // a reload must clear the registers written above
        load_program();
        check_word("pc", pc, '0);
        check_flag("wb_en", wb_en, 1'b0);
        sweep_regs();
    endtask

    task automatic test_addi();
        prog.delete();
        push_addi(rand_reg(), 5'd0, 12'h800);
        push_addi(rand_reg(), 5'd0, 12'hfff);
        push_addi(rand_reg(), 5'd0, 12'h7ff);
        for (int i = 0; i < 12; i++) begin
            push_addi(rand_reg(), rand_reg(), rand_imm());
        end
        load_program();
        run_program();
        sweep_regs();
    endtask

    task automatic test_logic_arith();
        prog.delete();
        for (int r = 1; r <= 6; r++) begin
            push_addi(reg_addr_t'(r), 5'd0, rand_imm());
        end
        // operands come from the six loaded registers
        for (int i = 0; i < 3; i++) begin
            push_r(alu_add, rand_reg(), reg_addr_t'(1 + i), reg_addr_t'(4 + i));
            push_r(alu_sub, rand_reg(), reg_addr_t'(2 + i), reg_addr_t'(1 + i));
            push_r(alu_and, rand_reg(), reg_addr_t'(3 + i), reg_addr_t'(2 + i));
            push_r(alu_or, rand_reg(), reg_addr_t'(4 + i), reg_addr_t'(3 + i));
            push_r(alu_xor, rand_reg(), reg_addr_t'(1 + i), reg_addr_t'(6 - i));
        end
        load_program();
        run_program();
        sweep_regs();
    endtask

    task automatic test_shift_slt();
        prog.delete();
        push_addi(5'd1, 5'd0, rand_imm());
        // upper bits set and low five bits giving 3
        push_addi(5'd2, 5'd0, 12'h7e3);
        push_addi(5'd3, 5'd0, 12'hfff);
        push_addi(5'd4, 5'd0, 12'h7ff);
        push_r(alu_sll, 5'd5, 5'd1, 5'd2);
        push_r(alu_srl, 5'd6, 5'd3, 5'd2);
        push_r(alu_sll, 5'd7, 5'd3, 5'd4);
        push_r(alu_srl, 5'd8, 5'd3, 5'd4);
        push_r(alu_slt, 5'd9, 5'd3, 5'd4);
        push_r(alu_slt, 5'd10, 5'd4, 5'd3);
        push_r(alu_slt, 5'd11, 5'd1, 5'd1);
        push_r(alu_slt, 5'd12, 5'd1, 5'd4);
        load_program();
        run_program();
        sweep_regs();
    endtask

    task automatic test_pc_noop();
        prog.delete();
        push_addi(5'd1, 5'd0, rand_imm());
        push_addi(5'd2, 5'd0, 12'h002);
        push_raw(32'h0000_0000);
        // lw x5, sra x3 and ori x3 fall outside the subset
        push_raw(32'h0000_a283);
        push_raw(32'h4020_d1b3);
        push_raw(32'h0010_e193);
        push_addi(5'd0, 5'd1, 12'h005);
        push_r(alu_add, 5'd0, 5'd1, 5'd1);
        push_addi(5'd4, 5'd0, rand_imm());
        load_program();
        run_program();
        sweep_regs();
    endtask

    task automatic test_pc_wrap();
        prog.delete();
        for (int i = 0; i < imem_depth; i++) begin
            push_addi(rand_reg(), rand_reg(), rand_imm());
        end
        load_program();
        run_program();
        sweep_regs();
    endtask

    initial begin
        rst = 1'b1;
        imem_we = 1'b0;
        imem_waddr = '0;
        imem_wdata = '0;
        dbg_addr = '0;
        exp_pc = '0;
        repeat (2) @(posedge clk);
        #1;
        test_reset();
        test_addi();
        test_logic_arith();
        test_shift_slt();
        test_pc_noop();
        test_pc_wrap();
        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
rtl/core_pkg.sv
rtl/isa_pkg.sv
rtl/fetch_unit.sv
rtl/register_file.sv
rtl/execute_unit.sv
rtl/rv_core.sv
+incdir+include
sim/tb_rv_core.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing -j 0 --top-module tb_rv_core -f verilog.f
	./obj_dir/Vtb_rv_core

clean:
	rm -rf obj_dir
